// File: test/memory_system_testdata.txt
# port (I, D or B for both) op (R or W) byte address, store data, expected load, all hex
# expected load is unused for writes; B runs the data op and an instruction read of one address
D W 00000000 11112222 00000000
D W 00000004 33334444 00000000
D W 00000008 55556666 00000000
D W 0000fffc 77778888 00000000
D R 00000000 00000000 11112222
D R 00000004 00000000 33334444
D R 00000008 00000000 55556666
D R 0000fffc 00000000 77778888
# instruction reads of words written through the data port
I R 00000004 00000000 33334444
I R 0000fffc 00000000 77778888
I R 00000000 00000000 11112222
I R 00000008 00000000 55556666
# both ports together, data first
D W 00000100 0000abcd 00000000
B W 00000100 cafe0001 cafe0001
B R 00000008 00000000 55556666
D R 00000100 00000000 cafe0001
# byte offsets inside one word
D W 00000200 aaaa0000 00000000
D W 00000201 aaaa0001 00000000
D W 00000202 aaaa0002 00000000
D W 00000203 aaaa0003 00000000
D R 00000200 00000000 aaaa0003
I R 00000202 00000000 aaaa0003
# back to back reads at different words
I R 00000100 00000000 cafe0001
D R 00000004 00000000 33334444
I R 00000200 00000000 aaaa0003
D R 0000fffc 00000000 77778888

// File: memory_system.f
+incdir+design
design/cpu_types_pkg.sv
design/mem_bus_pkg.sv
design/ram.sv
design/memory_control.sv
design/memory_system.sv
test/memory_system_assert.sv
test/memory_system_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the memory_system testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module memory_system_tb -f memory_system.f \
  && ./obj_dir/Vmemory_system_tb | tee /dev/stderr | grep -qx "ALL TESTS PASSED" \
  && echo "memory_system simulation passed" \
  || { echo "memory_system simulation failed"; exit 1; }

// File: test/memory_system_tb.sv
// drives the DUT from test/memory_system_testdata.txt, so run from the project root; every word is written before it is read
`timescale 1ns/100ps
`include "mem_settings.svh"

module memory_system_tb;
  import cpu_types_pkg::*;
  import mem_bus_pkg::*;

  localparam int HALF_PERIOD = 10;
  localparam int MAX_WAIT    = `MEM_LAT + 1;

  logic     CLK;
  logic     nRST;
  logic     iren;
  addr_t    iaddr;
  mem_rsp_t irsp;
  mem_req_t dreq;
  mem_rsp_t drsp;

  // operations as read from the data file
  logic [7:0] op_port [$];
  logic [7:0] op_kind [$];
  addr_t      op_addr [$];
  word_t      op_store [$];
  word_t      op_expect [$];

  int errors      = 0;
  int checks      = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  memory_system i_memory_system
  (
    .CLK   (CLK),
    .nRST  (nRST),
    .iren  (iren),
    .iaddr (iaddr),
    .irsp  (irsp),
    .dreq  (dreq),
    .drsp  (drsp)
  );

  always
  begin
    #HALF_PERIOD CLK = ~CLK;
  end

  // the limit stays at zero until the operations are known
  always @(posedge CLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit)
    begin
      $display("run hung: no completion after %0d cycles", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic check_load(input addr_t addr, input word_t got, input word_t want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Fail at %0t: load at address %h is %h, expected %h", $time, addr, got, want);
    end
  endtask

  task automatic check_owner(input grant_t got, input grant_t want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Fail at %0t: %s completed first, expected %s", $time, got.name(), want.name());
    end
  endtask

  task automatic check_wait(input logic got, input logic want, input string port_name);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Fail at %0t: %s wait_n is %b, expected %b", $time, port_name, got, want);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic load_ops();
    integer           fd;
    integer           n;
    logic [7:0]       tok;
    logic [7:0]       kind;
    addr_t            addr;
    word_t            store;
    word_t            want;
    logic [8*128-1:0] rest;
    logic             at_end;
    at_end = 1'b0;
    fd = $fopen("test/memory_system_testdata.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open test/memory_system_testdata.txt");
      at_end = 1'b1;
    end
    while (!at_end)
    begin
      n = $fscanf(fd, " %s", tok);
      if (n != 1)
      begin
        at_end = 1'b1;
      end
      else if (tok == "#")
      begin
        n = $fgets(rest, fd);
      end
      else
      begin
        n = $fscanf(fd, " %s %h %h %h", kind, addr, store, want);
        if (n != 4)
        begin
          errors++;
          $display("malformed test data line after %0d operations", op_port.size());
          at_end = 1'b1;
        end
        else
        begin
          op_port.push_back(tok);
          op_kind.push_back(kind);
          op_addr.push_back(addr);
          op_store.push_back(store);
          op_expect.push_back(want);
        end
      end
    end
    if (fd != 0)
    begin
      $fclose(fd);
    end
    if (op_port.size() == 0)
    begin
      errors++;
      $display("no operations were read from the test data file");
    end
  endtask

  task automatic check_idle(input int n_cycles);
    int k;
    for (k = 0; k < n_cycles; k++)
    begin
      @(negedge CLK);
      check_wait(irsp.wait_n, 1'b0, "instruction");
      check_wait(drsp.wait_n, 1'b0, "data");
    end
  endtask

  // one port alone; the marker word must show until the completing cycle
  task automatic run_single(input logic [7:0] port, input logic [7:0] kind, input addr_t addr,
                            input word_t store, input word_t want);
    int       waited;
    logic     done;
    mem_rsp_t rsp;
    waited = 0;
    done   = 1'b0;
    @(posedge CLK);
    if (port == "I")
    begin
      iren  <= 1'b1;
      iaddr <= addr;
    end
    else
    begin
      dreq.ren   <= (kind == "R");
      dreq.wen   <= (kind == "W");
      dreq.addr  <= addr;
      dreq.store <= store;
    end
    while (!done)
    begin
      @(negedge CLK);
      rsp = (port == "I") ? irsp : drsp;
      if (rsp.wait_n)
      begin
        done = 1'b1;
        if (kind == "R")
        begin
          check_load(addr, rsp.load, want);
        end
      end
      else
      begin
        waited++;
        check_load(addr, rsp.load, `MEM_BAD_WORD);
      end
    end
    if (waited > MAX_WAIT)
    begin
      errors++;
      $display("access at address %h took %0d wait cycles, more than %0d", addr, waited, MAX_WAIT);
    end
    @(posedge CLK);
    iren     <= 1'b0;
    dreq.ren <= 1'b0;
    dreq.wen <= 1'b0;
  endtask

  // both ports at once on one address; the instruction side always reads
  task automatic run_both(input logic [7:0] kind, input addr_t addr, input word_t store,
                          input word_t want);
    logic   d_done;
    logic   i_done;
    logic   first_set;
    grant_t first;
    d_done    = 1'b0;
    i_done    = 1'b0;
    first_set = 1'b0;
    first     = GRANT_I;
    @(posedge CLK);
    iren       <= 1'b1;
    iaddr      <= addr;
    dreq.ren   <= (kind == "R");
    dreq.wen   <= (kind == "W");
    dreq.addr  <= addr;
    dreq.store <= store;
    while (!(d_done && i_done))
    begin
      @(negedge CLK);
      if (!d_done && drsp.wait_n)
      begin
        d_done = 1'b1;
        if (!first_set)
        begin
          first     = GRANT_D;
          first_set = 1'b1;
        end
        if (kind == "R")
        begin
          check_load(addr, drsp.load, want);
        end
      end
      if (!i_done && irsp.wait_n)
      begin
        i_done = 1'b1;
        if (!first_set)
        begin
          first     = GRANT_I;
          first_set = 1'b1;
        end
        check_load(addr, irsp.load, want);
      end
      @(posedge CLK);
      if (d_done)
      begin
        dreq.ren <= 1'b0;
        dreq.wen <= 1'b0;
      end
      if (i_done)
      begin
        iren <= 1'b0;
      end
    end
    check_owner(first, GRANT_D);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    int idx;
    CLK   = 1'b0;
    nRST  = 1'b0;
    iren  = 1'b0;
    iaddr = '0;
    dreq  = '0;
    load_ops();
    cycle_limit = op_port.size() * (`MEM_LAT + 4) + 50;
    check_idle(4);
    @(posedge CLK);
    nRST <= 1'b1;
    // no request yet, so neither port may complete
    check_idle(3);
    for (idx = 0; idx < op_port.size(); idx++)
    begin
      case (op_port[idx])
        "I", "D":
        begin
          run_single(op_port[idx], op_kind[idx], op_addr[idx], op_store[idx], op_expect[idx]);
        end
        "B":
        begin
          run_both(op_kind[idx], op_addr[idx], op_store[idx], op_expect[idx]);
        end
        default:
        begin
          errors++;
          $display("unknown port code in test data operation %0d", idx);
        end
      endcase
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: test/memory_system_assert.sv
// handshake properties bound into memory_control; they only report in a build with assertions enabled
`timescale 1ns/100ps

module memory_system_assert
(
  input logic                  CLK,
  input logic                  nRST,
  input logic                  iren,
  input cpu_types_pkg::addr_t  iaddr,
  input mem_bus_pkg::mem_req_t dreq,
  input mem_bus_pkg::mem_rsp_t irsp,
  input mem_bus_pkg::mem_rsp_t drsp,
  input mem_bus_pkg::mem_req_t ram_req
);

  logic dreq_on;

  assign dreq_on = dreq.ren || dreq.wen;

  // ~~~~~~~~~~~~~~~~~~~~
  // responses
  // ~~~~~~~~~~~~~~~~~~~~

  one_done: assert property (@(posedge CLK) disable iff (!nRST)
    !(irsp.wait_n && drsp.wait_n))
    else $error("both ports completed in the same cycle");

  reset_wait: assert property (@(posedge CLK)
    !nRST |-> (!irsp.wait_n && !drsp.wait_n))
    else $error("a wait_n was high during reset");

  // ~~~~~~~~~~~~~~~~~~~~
  // requests
  // ~~~~~~~~~~~~~~~~~~~~

  one_enable: assert property (@(posedge CLK) disable iff (!nRST)
    !(ram_req.ren && ram_req.wen))
    else $error("RAM request has read and write enabled together");

  // a waiting requester must keep its request as it was
  i_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (iren && !irsp.wait_n) |=> (iren && $stable(iaddr)))
    else $error("instruction request changed before completion");

  d_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (dreq_on && !drsp.wait_n) |=> $stable(dreq))
    else $error("data request changed before completion");

endmodule

bind memory_control memory_system_assert i_memory_system_assert
(
  .CLK     (CLK),
  .nRST    (nRST),
  .iren    (iren),
  .iaddr   (iaddr),
  .dreq    (dreq),
  .irsp    (irsp),
  .drsp    (drsp),
  .ram_req (ram_req)
);

// File: design/memory_system.sv
// memory side of the teaching CPU; both ports must hold their requests until their wait_n is high
`timescale 1ns/100ps

module memory_system
(
  input  logic                  CLK,
  input  logic                  nRST,
  // instruction fetch
  input  logic                  iren,
  input  cpu_types_pkg::addr_t  iaddr,
  output mem_bus_pkg::mem_rsp_t irsp,
  // loads and stores
  input  mem_bus_pkg::mem_req_t dreq,
  output mem_bus_pkg::mem_rsp_t drsp
);
  import cpu_types_pkg::*;
  import mem_bus_pkg::*;

  // controller to RAM
  mem_req_t  ram_req;
  word_t     ram_load;
  ramstate_t ram_state;

  // ~~~~~~~~~~~~~~~~~~~~
  // arbiter
  // ~~~~~~~~~~~~~~~~~~~~

  memory_control i_memory_control
  (
    .CLK       (CLK),
    .nRST      (nRST),
    .iren      (iren),
    .iaddr     (iaddr),
    .dreq      (dreq),
    .irsp      (irsp),
    .drsp      (drsp),
    .ram_req   (ram_req),
    .ram_load  (ram_load),
    .ram_state (ram_state)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~

  ram i_ram
  (
    .CLK       (CLK),
    .nRST      (nRST),
    .ram_req   (ram_req),
    .ram_load  (ram_load),
    .ram_state (ram_state)
  );

endmodule

// File: design/memory_control.sv
// two-port front end of the RAM; data port wins ties but never preempts an access already counting
`timescale 1ns/100ps
`include "mem_settings.svh"

module memory_control
(
  input  logic                     CLK,
  input  logic                     nRST,
  // instruction port, read only
  input  logic                     iren,
  input  cpu_types_pkg::addr_t     iaddr,
  // data port
  input  mem_bus_pkg::mem_req_t    dreq,
  // responses
  output mem_bus_pkg::mem_rsp_t    irsp,
  output mem_bus_pkg::mem_rsp_t    drsp,
  // RAM side
  output mem_bus_pkg::mem_req_t    ram_req,
  input  cpu_types_pkg::word_t     ram_load,
  input  cpu_types_pkg::ramstate_t ram_state
);
  import cpu_types_pkg::*;
  import mem_bus_pkg::*;

  // instruction request in bus form
  mem_req_t ireq;

  logic     ireq_on;
  logic     dreq_on;
  logic     sel_on;
  logic     ram_done;

  grant_t   owner_pick;
  grant_t   owner_sel;
  grant_t   owner_q;
  logic     busy_q;
  logic     busy_d;

  // ~~~~~~~~~~~~~~~~~~~~
  // port requests
  // ~~~~~~~~~~~~~~~~~~~~

  // the instruction side can never write
  always_comb
  begin
    ireq.ren   = iren;
    ireq.wen   = 1'b0;
    ireq.addr  = iaddr;
    ireq.store = '0;
  end

  assign ireq_on = iren;
  assign dreq_on = dreq.ren || dreq.wen;

  // ~~~~~~~~~~~~~~~~~~~~
  // arbitration
  // ~~~~~~~~~~~~~~~~~~~~

  // data first when nothing is in flight
  assign owner_pick = dreq_on ? GRANT_D : GRANT_I;

  // an access in progress keeps its port until it completes
  assign owner_sel = busy_q ? owner_q : owner_pick;

  assign sel_on   = (owner_sel == GRANT_D) ? dreq_on : ireq_on;
  assign ram_done = sel_on && (ram_state == ACCESS);

  // stays set while the owner waits, drops on the completing cycle
  assign busy_d = sel_on && !ram_done;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      owner_q <= GRANT_I;
      busy_q  <= 1'b0;
    end
    else
    begin
      owner_q <= owner_sel;
      busy_q  <= busy_d;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // RAM request
  // ~~~~~~~~~~~~~~~~~~~~

  assign ram_req = (owner_sel == GRANT_D) ? dreq : ireq;

  // ~~~~~~~~~~~~~~~~~~~~
  // responses
  // ~~~~~~~~~~~~~~~~~~~~

  // the port without the RAM sees the marker word and keeps waiting
  always_comb
  begin
    irsp.wait_n = 1'b0;
    irsp.load   = `MEM_BAD_WORD;
    drsp.wait_n = 1'b0;
    drsp.load   = `MEM_BAD_WORD;
    if (owner_sel == GRANT_D)
    begin
      drsp.wait_n = ram_done;
      drsp.load   = ram_load;
    end
    else
    begin
      irsp.wait_n = ram_done;
      irsp.load   = ram_load;
    end
  end

endmodule

// File: design/ram.sv
// behavioral word RAM without init file, so every word is undefined until written; single port only
`timescale 1ns/100ps
`include "mem_settings.svh"

module ram
(
  input  logic                     CLK,
  input  logic                     nRST,
  input  mem_bus_pkg::mem_req_t    ram_req,
  output cpu_types_pkg::word_t     ram_load,
  output cpu_types_pkg::ramstate_t ram_state
);
  import cpu_types_pkg::*;

  typedef logic [3:0]                lat_cnt_t;
  typedef logic [`MEM_ADDR_BITS-1:0] widx_t;

  localparam int unsigned WORDS = 2 ** `MEM_ADDR_BITS;

  // word storage
  word_t     mem_array [WORDS];
  widx_t     widx;
  word_t     rd_word;
  logic      wr_en;

  // latency tracking
  logic [1:0] en_now;
  logic [1:0] en_q;
  addr_t      addr_q;
  lat_cnt_t   count_q;
  logic       req_on;
  logic       single_en;
  logic       req_changed;
  logic       lat_met;
  ramstate_t  state;

  // ~~~~~~~~~~~~~~~~~~~~
  // request decode
  // ~~~~~~~~~~~~~~~~~~~~

  assign en_now    = {ram_req.ren, ram_req.wen};
  assign req_on    = ram_req.ren || ram_req.wen;
  assign single_en = ram_req.ren ^ ram_req.wen;

  // anything other than an unchanged, enabled request restarts the count
  assign req_changed = !req_on ||
                       (ram_req.addr != addr_q) ||
                       (en_now != en_q);

  // only a request held with the same address and operation finishes its count
  assign lat_met = single_en &&
                   (ram_req.addr == addr_q) &&
                   (en_now == en_q) &&
                   (count_q >= `MEM_LAT);

  // ~~~~~~~~~~~~~~~~~~~~
  // latency registers
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      // both enables set never matches a legal request
      en_q    <= 2'b11;
      addr_q  <= '0;
      count_q <= '0;
    end
    else if (req_changed)
    begin
      en_q    <= en_now;
      addr_q  <= ram_req.addr;
      count_q <= '0;
    end
    else if (count_q < `MEM_LAT)
    begin
      count_q <= count_q + 4'd1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // state
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    case (en_now)
      2'b00:   state = FREE;
      2'b11:   state = ERROR;
      default: state = BUSY;
    endcase
    // reset also reads as ACCESS, callers keep their enables low then
    if (!nRST || lat_met)
    begin
      state = ACCESS;
    end
  end

  assign ram_state = state;

  // ~~~~~~~~~~~~~~~~~~~~
  // word array
  // ~~~~~~~~~~~~~~~~~~~~

  assign widx    = ram_req.addr[`MEM_ADDR_BITS+1:2];
  assign rd_word = mem_array[widx];
  assign wr_en   = (state == ACCESS) && ram_req.wen;

  // store lands at the edge that closes the ACCESS cycle
  always_ff @(posedge CLK)
  begin
    if (wr_en)
    begin
      mem_array[widx] <= ram_req.store;
    end
  end

  assign ram_load = (state == ACCESS) ? rd_word : `MEM_BAD_WORD;

endmodule

// File: design/mem_bus_pkg.sv
// request and response bundles between the ports, the controller and the RAM; requests are held until wait_n
package mem_bus_pkg;
  import cpu_types_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~
  // request side
  // ~~~~~~~~~~~~~~~~~~~~

  // a requester holds all of these stable until its wait_n goes high
  // ren and wen together are illegal and make the RAM report ERROR
  typedef struct packed
  {
    logic  ren;
    logic  wen;
    addr_t addr;
    word_t store;
  } mem_req_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // response side
  // ~~~~~~~~~~~~~~~~~~~~

  // wait_n is high for the single cycle the transfer happens
  // load is only meaningful in that cycle
  typedef struct packed
  {
    logic  wait_n;
    word_t load;
  } mem_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // arbitration
  // ~~~~~~~~~~~~~~~~~~~~

  // port that currently drives the RAM request
  typedef enum logic
  {
    GRANT_I,
    GRANT_D
  } grant_t;

endpackage

// File: design/cpu_types_pkg.sv
// data and state types of the memory side; addresses are byte addresses and words are 32 bits
package cpu_types_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // data widths
  // ~~~~~~~~~~~~~~~~~~~~

  // one machine word, the unit of every RAM transfer
  typedef logic [31:0] word_t;

  // byte address as issued by the processor
  // only bits 15:2 reach the word array, the low two bits are ignored
  typedef logic [31:0] addr_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // RAM state
  // ~~~~~~~~~~~~~~~~~~~~

  // reported by the RAM every cycle
  typedef enum logic [1:0]
  {
    // no enable raised
    FREE,
    // one enable raised, latency still counting
    BUSY,
    // transfer happens in this cycle
    ACCESS,
    // read and write raised together
    ERROR
  } ramstate_t;

endpackage

// File: design/mem_settings.svh
// RAM build constants used by design and testbench alike; MEM_LAT must fit in 4 bits and MEM_ADDR_BITS above 14 exceeds addr bits 15:2
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// timing
// ~~~~~~~~~~~~~~~~~~~~

// extra cycles a stable request waits before the RAM reports ACCESS
// zero gives an access in the cycle after the request appears
`define MEM_LAT 4'd2

// ~~~~~~~~~~~~~~~~~~~~
// geometry
// ~~~~~~~~~~~~~~~~~~~~

// word index width, taken from byte address bits starting at bit 2
`define MEM_ADDR_BITS 14

// ~~~~~~~~~~~~~~~~~~~~
// markers
// ~~~~~~~~~~~~~~~~~~~~

// shown on the load data whenever the RAM is not in ACCESS
`define MEM_BAD_WORD 32'hBAD1_BAD1

`endif
